//--- bootRom.hex
// one 128-bit ROM tile per line, tile 0 first, 32 hex digits, msb on the left
00112233445566778899aabbccddeeff
0f1e2d3c4b5a69788796a5b4c3d2e1f0
deadbeefcafef00d0123456789abcdef
30003000300030003000300030003000
a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0
13579bdf02468ace13579bdf02468ace
ffffffff00000000ffffffff00000001
8000000000000000000000000000007f
1122334455667788112233445566778f
fedcba98765432100123456789abcdef
0badc0de0badc0de0badc0de0badc0de
c3c3c3c33c3c3c3c9696969669696969
00000000000000000000000000000000
76543210fedcba9876543210fedcba98
e1e2e3e4e5e6e7e8e9eaebecedeeeff0
7fffffff800000017ffffffe80000002

//--- filelist.f
ringPkg.sv
ringLink.sv
tileMemNode.sv
ringRequester.sv
ringTop.sv
tbClockGen.sv
tbRingTop.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tbRingTop
FILELIST  = filelist.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf $(OBJDIR)

//--- tbRingTop.sv
// Testbench for the ring memory subsystem.
// Reads bootRom.hex from the working directory, only its sixteen tiles are loaded.
// SRAM loads go only to tiles that were stored earlier in the run.
// Responses are checked on the falling edge against a queue kept in request order.
// Watchdog budget grows by 200 cycles per issued request.

`timescale 1ns/1ps

module tbRingTop;

	localparam int         romDepth = 2048;
	localparam int         ramDepth = 512;
	localparam int         ramIxW   = $clog2(ramDepth);
	localparam logic [7:0] nodeId   = 8'h21;
	localparam logic [31:0] romEnd  = romDepth * 16;
	localparam logic [31:0] ramEnd  = ringPkg::ramBase + ramDepth * 16;

	logic                 clock;
	logic                 arstN;
	logic                 reqStrobe;
	ringPkg::ringOpm_t    reqOpm;
	logic [31:0]          reqAddr;
	logic [127:0]         reqData;
	logic [7:0]           reqTag;
	logic                 busy;
	logic                 respValid;
	logic [7:0]           respTag;
	ringPkg::respStatus_t respStatus;
	logic [127:0]         respData;

	logic [127:0]         romImage [16];     // file contents
	logic [127:0]         ramModel [ramDepth];
	logic [31:0]          ramWritten [$];    // stored tile addresses
	logic [7:0]           expTag [$];
	ringPkg::respStatus_t expStatus [$];
	logic [127:0]         expData [$];
	integer               seed = 32'hf48b_b9b8;
	int                   issued = 0;
	int                   passCount = 0;
	int                   failCount = 0;
	int                   markPass = 0;      // counts at the start of a test
	int                   markFail = 0;

	tbClockGen clockGen (.clock(clock), .arstN(arstN));

	ringTop #(.romDepth(romDepth), .ramDepth(ramDepth), .nodeId(nodeId)) u_ringTop (
		.clock(clock), .arstN(arstN), .reqStrobe(reqStrobe), .reqOpm(reqOpm),
		.reqAddr(reqAddr), .reqData(reqData), .reqTag(reqTag), .busy(busy),
		.respValid(respValid), .respTag(respTag), .respStatus(respStatus),
		.respData(respData)
	);

	function automatic logic [31:0] randomWord();
		return $random(seed);
	endfunction

	function automatic logic [127:0] randomTile();
		return {randomWord(), randomWord(), randomWord(), randomWord()};
	endfunction

	function automatic logic [ramIxW-1:0] ramIndex(input logic [31:0] addr);
		logic [31:0] off;
		off = (addr - ringPkg::ramBase) >> 4;
		return off[ramIxW-1:0];
	endfunction

	// expected {status, data} from the address map
	function automatic logic [129:0] expectedResp(input ringPkg::ringOpm_t opm,
		input logic [31:0] addr, input logic [127:0] data);
		logic [31:0] tile;
		tile = addr >> 4;
		if (addr[31:30] != 2'b00)
			return {ringPkg::stFault, 128'h0}; // fault wins over any opcode
		if (addr[31:16] > 16'h0002)
			return {ringPkg::stUnclaimed, data}; // goes round untouched
		if (opm == ringPkg::opStx)
			return {ringPkg::stOk, data}; // echo, even when dropped
		if (addr < romEnd)
			return {ringPkg::stOk, romImage[tile[3:0]]};
		if (addr >= ringPkg::ramBase && addr < ramEnd)
			return {ringPkg::stOk, ramModel[ramIndex(addr)]};
		if (addr[31:16] == 16'h0002)
			return {ringPkg::stOk, {8{16'h3000}}}; // nop page
		return {ringPkg::stOk, 128'h0}; // zero page and gaps
	endfunction

	// called on a falling edge, returns on one
	task automatic sendReq(input ringPkg::ringOpm_t opm, input logic [31:0] addr,
		input logic [127:0] data);
		logic [129:0] want;
		while (busy)
			@(negedge clock);
		want = expectedResp(opm, addr, data);
		expTag.push_back(reqTag);
		expStatus.push_back(ringPkg::respStatus_t'(want[129:128]));
		expData.push_back(want[127:0]);
		if (opm == ringPkg::opStx && addr >= ringPkg::ramBase && addr < ramEnd)
			ramModel[ramIndex(addr)] = data;
		reqOpm    = opm;
		reqAddr   = addr;
		reqData   = data;
		reqStrobe = 1'b1;
		issued++;
		@(negedge clock);
		reqStrobe = 1'b0;
		if (busy !== 1'b1)
		begin
			$display("FAIL %0t: busy is %b after the strobe for tag %h", $time, busy,
				reqTag);
			failCount++;
		end
		reqTag    = reqTag + 8'd1; // next tag
	endtask

	task automatic finishTest(input string name);
		while (expTag.size() != 0)
			@(negedge clock); // watchdog catches a lost response
		$display("test %s done: %0d ok, %0d bad", name, passCount - markPass,
			failCount - markFail);
		markPass = passCount;
		markFail = failCount;
	endtask

	// compare each response with the head of the queue
	always @(negedge clock)
	begin : compare
		logic [7:0]           wantTag;
		ringPkg::respStatus_t wantStatus;
		logic [127:0]         wantData;
		if (arstN && respValid)
		begin
			if (expTag.size() == 0)
			begin
				$display("response with tag %h at %0t but no request was outstanding",
					respTag, $time);
				failCount++;
			end
			else
			begin
				wantTag    = expTag.pop_front();
				wantStatus = expStatus.pop_front();
				wantData   = expData.pop_front();
				if (respTag !== wantTag || respStatus !== wantStatus || respData !== wantData)
				begin
					$display("FAIL %0t: tag %h status %0d data %h", $time, respTag,
						respStatus, respData);
					$display("FAIL %0t: expected tag %h status %0d data %h", $time, wantTag,
						wantStatus, wantData);
					failCount++;
				end
				else
					passCount++;
			end
		end
	end

	initial
	begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < 200 * issued + 100)
		begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout after %0d cycles, %0d requests issued", cycles, issued);
		$display("STATUS: FAIL");
		$finish;
	end

	initial
	begin : mainFlow
		logic [31:0] addr;
		reqStrobe = 1'b0;
		reqOpm    = ringPkg::opIdle;
		reqAddr   = '0;
		reqData   = '0;
		reqTag    = 8'h00;
		$readmemh("bootRom.hex", romImage);
		@(posedge arstN);
		@(negedge clock);

		for (int i = 0; i < 16; i++)
			sendReq(ringPkg::opLdx, 32'(i) << 4, randomTile());
		sendReq(ringPkg::opPfx, 32'h0000_0058, randomTile()); // tile 5, offset ignored
		finishTest("romLoad");

		for (int i = 0; i < 8; i++)
		begin
			addr = ringPkg::ramBase + ((randomWord() & 32'(ramDepth - 1)) << 4);
			sendReq(ringPkg::opStx, addr, randomTile());
			ramWritten.push_back(addr);
		end
		foreach (ramWritten[i])
			sendReq(ringPkg::opLdx, ramWritten[i], randomTile());
		addr = ramEnd - 32'd16; // last SRAM tile
		sendReq(ringPkg::opStx, addr, randomTile());
		sendReq(ringPkg::opLdx, addr, randomTile()); // right behind the store
		finishTest("sramStoreLoad");

		for (int i = 0; i < 4; i++)
		begin
			sendReq(ringPkg::opLdx, ringPkg::zeroBase + (randomWord() & 32'hfff0), randomTile());
			sendReq(ringPkg::opLdx, ringPkg::nopBase + (randomWord() & 32'hfff0), randomTile());
		end
		sendReq(ringPkg::opLdx, 32'h0000_9a40, randomTile()); // gap below SRAM
		sendReq(ringPkg::opPfx, 32'h0000_e000, randomTile()); // gap above SRAM
		finishTest("specialPages");

		sendReq(ringPkg::opLdx, 32'h4000_0000 | randomWord(), randomTile());
		sendReq(ringPkg::opStx, 32'hc000_0100, randomTile());
		sendReq(ringPkg::opPfx, 32'h8001_2340, randomTile());
		sendReq(ringPkg::opLdx, 32'h0003_0000, randomTile()); // just above low region
		sendReq(ringPkg::opStx, 32'h1234_5670, randomTile());
		sendReq(ringPkg::opLdx, 32'h0003_0000 | (randomWord() & 32'h3ffc_ffff), randomTile());
		finishTest("faultPassThrough");

		for (int i = 0; i < 20; i++)
		begin
			case (i % 4)
				0: sendReq(ringPkg::opLdx, 32'(i % 16) << 4, randomTile());
				1:
				begin
					addr = ringPkg::ramBase + ((randomWord() & 32'(ramDepth - 1)) << 4);
					sendReq(ringPkg::opStx, addr, randomTile());
					ramWritten.push_back(addr);
				end
				2: sendReq(ringPkg::opLdx, ramWritten[$], randomTile());
				default: sendReq(ringPkg::opLdx, ringPkg::nopBase + 32'(i * 16), randomTile());
			endcase
		end
		finishTest("pipelineOrder");

		$display("checks passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- tbClockGen.sv
// Clock and reset for the ring testbench.
// Clock starts low, reset is released on a falling edge after resetCycles cycles.

`timescale 1ns/1ps

module tbClockGen #(
	parameter int halfPeriod  = 5, // ns, 10 ns period
	parameter int resetCycles = 2
) (
	output logic clock,
	output logic arstN
);

	initial
	begin
		clock = 1'b0;
		forever #(halfPeriod) clock = ~clock;
	end

	initial
	begin
		arstN = 1'b0;
		repeat (resetCycles) @(negedge clock); // clear of the rising edge
		arstN = 1'b1;
	end

endmodule

//--- ringTop.sv
// Two-node ring: requester and tile memory node.
// Three registered slots circulate, so up to three messages are in flight.
// Strobe to respValid takes at least 4 cycles, and responses keep request order.

`timescale 1ns/1ps

module ringTop #(
	parameter int         romDepth = 2048,
	parameter int         ramDepth = 512,
	parameter logic [7:0] nodeId   = 8'h21
) (
	input  logic                          clock,
	input  logic                          arstN,
	input  logic                          reqStrobe,  // one-cycle pulse
	input  ringPkg::ringOpm_t             reqOpm,
	input  logic [ringPkg::addrWidth-1:0] reqAddr,
	input  logic [ringPkg::tileWidth-1:0] reqData,
	input  logic [7:0]                    reqTag,
	output logic                          busy,       // request not yet in ring
	output logic                          respValid,  // one-cycle pulse
	output logic [7:0]                    respTag,
	output ringPkg::respStatus_t          respStatus,
	output logic [ringPkg::tileWidth-1:0] respData
);

	ringLink linkA (); // requester to memory node
	ringLink linkB (); // memory node back to requester

	ringRequester #(
		.nodeId (nodeId)
	) uRequester (
		.clock      (clock),
		.arstN      (arstN),
		.reqStrobe  (reqStrobe),
		.reqOpm     (reqOpm),
		.reqAddr    (reqAddr),
		.reqData    (reqData),
		.reqTag     (reqTag),
		.busy       (busy),
		.respValid  (respValid),
		.respTag    (respTag),
		.respStatus (respStatus),
		.respData   (respData),
		.ringIn     (linkB.sink),
		.ringOut    (linkA.source)
	);

	tileMemNode #(
		.romDepth (romDepth),
		.ramDepth (ramDepth)
	) uMemNode (
		.clock (clock),
		.arstN (arstN),
		.up    (linkA.sink),
		.down  (linkB.source)
	);

endmodule

//--- ringRequester.sv
// Host-facing ring node, one pending request at a time.
// A request goes into the first idle incoming slot, never into a slot freed
// by extraction in the same cycle.
// Responses whose seq carries nodeId are taken off the ring, and respValid
// follows one cycle after the slot shows up on ringIn.
// The host must not strobe while busy is high and cannot stall responses.

`timescale 1ns/1ps

module ringRequester #(
	parameter logic [7:0] nodeId = 8'h21 // our id in seq[15:8]
) (
	input  logic                          clock,
	input  logic                          arstN,
	input  logic                          reqStrobe,
	input  ringPkg::ringOpm_t             reqOpm,
	input  logic [ringPkg::addrWidth-1:0] reqAddr,
	input  logic [ringPkg::tileWidth-1:0] reqData,
	input  logic [7:0]                    reqTag,
	output logic                          busy,
	output logic                          respValid,
	output logic [7:0]                    respTag,
	output ringPkg::respStatus_t          respStatus,
	output logic [ringPkg::tileWidth-1:0] respData,
	ringLink.sink                         ringIn,
	ringLink.source                       ringOut
);

	logic                          pendValid; // request waiting for a slot
	ringPkg::ringOpm_t             pendOpm;
	logic [ringPkg::addrWidth-1:0] pendAddr;
	logic [ringPkg::tileWidth-1:0] pendData;
	logic [7:0]                    pendTag;

	logic                 inOwn;    // incoming slot is ours
	logic                 inIdle;   // incoming slot is empty
	logic                 doInject;
	logic                 accept;
	ringPkg::respStatus_t inStatus; // status of the incoming slot

	always_comb
	begin
		inIdle   = (ringIn.opm == ringPkg::opIdle);
		inOwn    = !inIdle && (ringIn.seq[ringPkg::seqWidth-1 -: 8] == nodeId);
		doInject = pendValid && inIdle;
		accept   = reqStrobe && !pendValid;
		case (ringIn.opm)
			ringPkg::opOkLd,
			ringPkg::opOkSt:  inStatus = ringPkg::stOk;
			ringPkg::opFault: inStatus = ringPkg::stFault;
			default:          inStatus = ringPkg::stUnclaimed; // went round unserved
		endcase
	end

	assign busy = pendValid;

	// control state
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			pendValid   <= 1'b0;
			respValid   <= 1'b0;
			ringOut.opm <= ringPkg::opIdle;
		end
		else
		begin
			if (accept)
				pendValid <= 1'b1;
			else if (doInject)
				pendValid <= 1'b0; // in the ring now
			respValid <= inOwn;
			if (inOwn)
				ringOut.opm <= ringPkg::opIdle; // extracted, slot freed
			else if (doInject)
				ringOut.opm <= pendOpm;
			else
				ringOut.opm <= ringIn.opm; // not ours, forward
		end
	end

	// payload registers
	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			pendOpm  <= reqOpm;
			pendAddr <= reqAddr;
			pendData <= reqData;
			pendTag  <= reqTag;
		end
		if (inOwn)
		begin
			respTag    <= ringIn.seq[7:0];
			respStatus <= inStatus;
			respData   <= ringIn.data;
		end
		if (doInject)
		begin
			ringOut.seq  <= {nodeId, pendTag};
			ringOut.addr <= pendAddr;
			ringOut.data <= pendData;
		end
		else
		begin
			ringOut.seq  <= ringIn.seq; // don't-care on an extracted slot
			ringOut.addr <= ringIn.addr;
			ringOut.data <= ringIn.data;
		end
	end

	// host protocol, one request in hand at a time
	assertNoStrobeBusy: assert property (@(posedge clock) disable iff (!arstN)
		busy |-> !reqStrobe);

	// a response is never delivered twice in a row
	assertNoDupResp: assert property (@(posedge clock) disable iff (!arstN)
		respValid |=> !(respValid && (respTag == $past(respTag))));

endmodule

//--- tileMemNode.sv
// Ring memory node with ROM, SRAM, zero page and nop page.
// Two-stage pipeline: a slot launched on up at edge N is on down after edge N+2.
// Stage one reads both tile arrays and writes the SRAM, so a load right behind
// a store to the same tile sees the new tile.
// The ROM is filled from bootRom.hex, tiles past the end of the file are unset.
// Stores outside the SRAM are acknowledged but dropped.
// romDepth and ramDepth must be powers of two, at least 2.

`timescale 1ns/1ps

module tileMemNode #(
	parameter int romDepth = 2048, // ROM tiles
	parameter int ramDepth = 512   // SRAM tiles
) (
	input logic   clock,
	input logic   arstN,
	ringLink.sink   up,
	ringLink.source down
);

	localparam int romIxW = $clog2(romDepth);
	localparam int ramIxW = $clog2(ramDepth);
	localparam logic [ringPkg::addrWidth-1:0] romBytes = romDepth * 16;
	localparam logic [ringPkg::addrWidth-1:0] ramBytes = ramDepth * 16;

	logic [ringPkg::tileWidth-1:0] romTiles [romDepth];
	logic [ringPkg::tileWidth-1:0] ramTiles [ramDepth];

	logic [ringPkg::addrWidth-1:0] romOff; // offset into ROM region
	logic [ringPkg::addrWidth-1:0] ramOff; // offset into SRAM region
	logic [romIxW-1:0]             romIx;
	logic [ramIxW-1:0]             ramIx;
	logic inLoad, inStore;                  // opcode class of incoming slot
	logic inLow, inRom, inRam, inZero, inNop, inFault; // region flags
	logic ramWe;

	// stage one
	logic [ringPkg::seqWidth-1:0]  s1Seq;
	ringPkg::ringOpm_t             s1Opm;
	logic [ringPkg::addrWidth-1:0] s1Addr;
	logic [ringPkg::tileWidth-1:0] s1Data;
	logic s1IsLoad, s1IsStore;
	logic s1IsLow, s1IsRom, s1IsRam, s1IsZero, s1IsNop, s1IsFault;
	logic [ringPkg::tileWidth-1:0] romRd; // registered ROM read
	logic [ringPkg::tileWidth-1:0] ramRd; // registered SRAM read

	// stage two next values
	ringPkg::ringOpm_t             nxtOpm;
	logic [ringPkg::tileWidth-1:0] nxtData;

	initial
	begin
		$readmemh("bootRom.hex", romTiles); // boot image
	end

	// decode of the incoming slot
	always_comb
	begin
		romOff  = up.addr - ringPkg::romBase; // wraps huge below base
		ramOff  = up.addr - ringPkg::ramBase;
		romIx   = romOff[romIxW+3:4];
		ramIx   = ramOff[ramIxW+3:4];
		inLoad  = (up.opm == ringPkg::opLdx) || (up.opm == ringPkg::opPfx);
		inStore = (up.opm == ringPkg::opStx);
		inFault = (up.addr[31:30] != 2'b00);
		inLow   = (up.addr[31:16] <= ringPkg::nopBase[31:16]); // 0x00000..0x2ffff
		inRom   = (romOff < romBytes);
		inRam   = (ramOff < ramBytes);
		inZero  = (up.addr[31:16] == ringPkg::zeroBase[31:16]);
		inNop   = (up.addr[31:16] == ringPkg::nopBase[31:16]);
		ramWe   = inStore && inRam;
	end

	// stage one control and decode flags
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			s1Opm     <= ringPkg::opIdle;
			s1IsLoad  <= 1'b0;
			s1IsStore <= 1'b0;
			s1IsLow   <= 1'b0;
			s1IsRom   <= 1'b0;
			s1IsRam   <= 1'b0;
			s1IsZero  <= 1'b0;
			s1IsNop   <= 1'b0;
			s1IsFault <= 1'b0;
		end
		else
		begin
			s1Opm     <= up.opm;
			s1IsLoad  <= inLoad;
			s1IsStore <= inStore;
			s1IsLow   <= inLow;
			s1IsRom   <= inRom;
			s1IsRam   <= inRam;
			s1IsZero  <= inZero;
			s1IsNop   <= inNop;
			s1IsFault <= inFault;
		end
	end

	// stage one payload and tile arrays
	always_ff @(posedge clock)
	begin
		s1Seq  <= up.seq;
		s1Addr <= up.addr;
		s1Data <= up.data;
		romRd  <= romTiles[romIx];
		ramRd  <= ramTiles[ramIx]; // old tile on a same-edge store, unused then
		if (ramWe)
		begin
			ramTiles[ramIx] <= up.data;
		end
	end

	// stage two response builder
	always_comb
	begin
		nxtOpm  = s1Opm; // pass through by default
		nxtData = s1Data;
		if (s1IsFault && (s1IsLoad || s1IsStore))
		begin
			nxtOpm  = ringPkg::opFault;
			nxtData = '0;
		end
		else if (s1IsLow && s1IsLoad)
		begin
			nxtOpm = ringPkg::opOkLd;
			if (s1IsRom)
				nxtData = romRd;
			else if (s1IsRam)
				nxtData = ramRd;
			else if (s1IsNop)
				nxtData = ringPkg::nopFill;
			else
				nxtData = '0; // zero page and unmapped gaps
		end
		else if (s1IsLow && s1IsStore)
		begin
			nxtOpm = ringPkg::opOkSt; // echo the stored tile
		end
	end

	// stage two registers drive the down link
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			down.opm <= ringPkg::opIdle;
		else
			down.opm <= nxtOpm;
	end

	always_ff @(posedge clock)
	begin
		down.seq  <= s1Seq;
		down.addr <= s1Addr;
		down.data <= nxtData;
	end

	// every SRAM write leaves two edges later as a store ack
	assertRamWrite: assert property (@(posedge clock) disable iff (!arstN)
		ramWe |-> ##2 (down.opm == ringPkg::opOkSt));

	// the region map must not overlap for the chosen depths
	assertRegions: assert property (@(posedge clock) disable iff (!arstN)
		$onehot0({s1IsRom, s1IsRam, s1IsZero, s1IsNop, s1IsFault}));

endmodule

//--- ringLink.sv
// One ring slot between two nodes.
// There is no handshake: every clock edge moves the slot one stage.
// A slot whose opm is opIdle carries nothing and its other fields are don't-care.

`timescale 1ns/1ps

interface ringLink;

	logic [ringPkg::seqWidth-1:0]  seq;  // {node id, tag}
	ringPkg::ringOpm_t             opm;  // operation or response code
	logic [ringPkg::addrWidth-1:0] addr; // byte address
	logic [ringPkg::tileWidth-1:0] data; // tile payload

	// driving node
	modport source
	(
		output seq,
		output opm,
		output addr,
		output data
	);

	// receiving node
	modport sink
	(
		input seq,
		input opm,
		input addr,
		input data
	);

endinterface

//--- ringPkg.sv
// Shared definitions for the ring-bus memory subsystem.
// The upper seq byte is the requester node id and the lower byte is the tag.
// The address map covers only the low region 0x00000..0x2FFFF.
// Anything with a nonzero top two address bits is answered with a fault.
// ROM and SRAM sizes are module parameters and are not fixed here.
// romDepth must stay at or below 3072 tiles so that the ROM does not reach the SRAM.

package ringPkg;

	// slot operation, response opcodes carry 01 in the top two bits
	typedef enum logic [7:0]
	{
		opIdle  = 8'h00, // empty slot
		opLdx   = 8'h11, // load tile
		opStx   = 8'h12, // store tile
		opPfx   = 8'h13, // prefetch, served as a load
		opOkLd  = 8'h41, // load response
		opOkSt  = 8'h42, // store response
		opFault = 8'h4f  // bad address response
	} ringOpm_t;

	// status as seen by the host
	typedef enum logic [1:0]
	{
		stOk        = 2'd0,
		stFault     = 2'd1,
		stUnclaimed = 2'd2 // came back round unserved
	} respStatus_t;

	localparam int seqWidth  = 16;  // {node id, tag}
	localparam int addrWidth = 32;  // byte address
	localparam int tileWidth = 128; // one 16-byte tile

	// region bases, byte addresses
	localparam logic [addrWidth-1:0] romBase  = 32'h0000_0000;
	localparam logic [addrWidth-1:0] ramBase  = 32'h0000_c000;
	localparam logic [addrWidth-1:0] zeroBase = 32'h0001_0000; // 64 KiB of zeros
	localparam logic [addrWidth-1:0] nopBase  = 32'h0002_0000; // 64 KiB of nops

	// eight copies of the 16-bit nop word
	localparam logic [tileWidth-1:0] nopFill = {8{16'h3000}};

endpackage
